//--- project.f
source/joy_pkg.sv
source/adc_serial_ctrl.sv
source/joy_ring_tap.sv
source/joystick.sv
verif/tb_clkgen.sv
verif/adc_model.sv
verif/tb_joystick.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the joystick testbench with Verilator and runs it.
# The exit status is the simulator's own, so a $fatal fails the script.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_joystick -f project.f -o sim_tb_joystick; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_joystick
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

echo "Simulation finished"
exit 0

//--- source/adc_serial_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module adc_serial_ctrl import joy_pkg::*; #(
  parameter int CONV_CYCLES = 8,
  parameter int SCK_DIV     = 2
) (
  input  wire              clk,
  input  wire              i_rst_n,
  input  wire              i_adc_sdo,
  output logic             o_adc_convst,
  output logic             o_adc_sck,
  output logic             o_adc_sdi,
  output logic             o_sample_valid,
  output adc_sample_t      o_sample,
  output adc_chan_t        o_sample_chan
);

  typedef enum logic [1:0] {
    ST_CONV,
    ST_SHIFT,
    ST_DONE
  } state_e;

  localparam int CNT_MAX   = (CONV_CYCLES > SCK_DIV) ? CONV_CYCLES : SCK_DIV;
  localparam int CNT_W     = $clog2(CNT_MAX) + 1;
  localparam int HALF_W    = $clog2(2 * ADC_BITS);
  localparam int HALF_LAST = 2 * ADC_BITS - 1;

  state_e            state;
  logic [CNT_W-1:0]  cnt;        // Clocks within convert or one SCK half.
  logic [HALF_W-1:0] half_cnt;   // SCK half-period, even halves are low.
  adc_chan_t         pend_chan;  // Channel configured in this frame.
  adc_chan_t         read_chan;  // Channel whose result is shifting out.
  logic              running;
  logic              armed;
  adc_cfg_t          cfg_sr;
  adc_sample_t       sample_sr;
  logic              cnt_end;
  logic              sck_rise;
  logic              sck_fall;

  assign cnt_end  = (state == ST_CONV) ? (cnt == CNT_W'(CONV_CYCLES - 1))
                                       : (cnt == CNT_W'(SCK_DIV - 1));
  assign sck_rise = (state == ST_SHIFT) && cnt_end && !half_cnt[0];
  assign sck_fall = (state == ST_SHIFT) && cnt_end && half_cnt[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame sequencing
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= ST_DONE;
      cnt       <= '0;
      half_cnt  <= '0;
      pend_chan <= '0;
      read_chan <= '0;
      running   <= 1'b0;
      armed     <= 1'b0;
    end else begin
      case (state)
        ST_CONV: begin
          if (cnt_end) begin
            cnt      <= '0;
            half_cnt <= '0;
            state    <= ST_SHIFT;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_SHIFT: begin
          if (cnt_end) begin
            cnt <= '0;
            if (half_cnt == HALF_W'(HALF_LAST)) begin
              state <= ST_DONE;
            end else begin
              half_cnt <= half_cnt + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          // Idle clock. The first one after reset only starts the scan.
          cnt     <= '0;
          state   <= ST_CONV;
          running <= 1'b1;
          if (running) begin
            read_chan <= pend_chan;
            armed     <= 1'b1;  // From now on a configured channel is pending.
            if (pend_chan == adc_chan_t'(ADC_CHANNELS - 1)) begin
              pend_chan <= '0;
            end else begin
              pend_chan <= pend_chan + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial data
  always_ff @(posedge clk) begin
    if ((state == ST_CONV) && cnt_end) begin
      cfg_sr <= adc_cfg_word(pend_chan);  // First bit is out as CONVST falls.
    end else if (sck_fall) begin
      cfg_sr <= {cfg_sr[ADC_CFG_BITS-2:0], 1'b0};
    end
    if (sck_rise) begin
      sample_sr <= {sample_sr[ADC_BITS-2:0], i_adc_sdo};  // MSB first.
    end
  end

  assign o_adc_convst   = (state == ST_CONV);
  assign o_adc_sck      = (state == ST_SHIFT) && half_cnt[0];
  assign o_adc_sdi      = (state == ST_SHIFT) && cfg_sr[ADC_CFG_BITS-1];
  assign o_sample_valid = (state == ST_DONE) && armed;
  assign o_sample       = sample_sr;
  assign o_sample_chan  = read_chan;

  ast_convst_sck: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    !(o_adc_convst && o_adc_sck)
  ) else $error("CONVST and SCK are high together");

  ast_valid_pulse: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_sample_valid |=> !o_sample_valid
  ) else $error("Sample valid held for more than one clock");

endmodule

`default_nettype wire

//--- source/joy_pkg.sv
`default_nettype none

package joy_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Converter
  localparam int ADC_BITS     = 12;
  localparam int ADC_CHANNELS = 8;
  localparam int ADC_CFG_BITS = 6;  // S/D, O/S, S1, S0, UNI, SLP.

  typedef logic [ADC_BITS-1:0]             adc_sample_t;
  typedef logic [$clog2(ADC_CHANNELS)-1:0] adc_chan_t;
  typedef logic [ADC_CFG_BITS-1:0]         adc_cfg_t;

  // Single-ended, unipolar, awake. Odd/sign picks the low channel bit.
  function automatic adc_cfg_t adc_cfg_word(adc_chan_t chan);
    return {1'b1, chan[0], chan[2], chan[1], 1'b1, 1'b0};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Keys
  localparam int NUM_KEYS = 5;

  typedef enum logic [2:0] {
    KEY_UP     = 3'd0,
    KEY_RIGHT  = 3'd1,
    KEY_SELECT = 3'd2,
    KEY_DOWN   = 3'd3,
    KEY_LEFT   = 3'd4
  } joy_key_e;

  typedef logic [2:0] key_code_t;

  localparam key_code_t KEY_CODE_UP     = 3'b101;
  localparam key_code_t KEY_CODE_RIGHT  = 3'b011;
  localparam key_code_t KEY_CODE_SELECT = 3'b010;
  localparam key_code_t KEY_CODE_DOWN   = 3'b001;
  localparam key_code_t KEY_CODE_LEFT   = 3'b000;  // 100, 110 and 111 decode to no key.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ring bus
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_mask_t;

endpackage

`default_nettype wire

//--- source/joy_ring_tap.sv
`timescale 1ns/1ps
`default_nettype none

module joy_ring_tap import joy_pkg::*; #(
  parameter int        SIZE        = 3,
  parameter bus_addr_t ADDR_BASE   = 32'h0000_0100,
  parameter int        JOY_CHANNEL = 3
) (
  input  wire              clk,
  input  wire              i_rst_n,
  input  wire              i_sample_valid,
  input  wire adc_sample_t i_sample,
  input  wire adc_chan_t   i_sample_chan,
  input  wire              i_bus_req,
  input  wire              i_bus_ack,
  input  wire              i_bus_write,
  input  wire bus_addr_t   i_bus_addr,
  input  wire bus_data_t   i_bus_data,
  input  wire bus_mask_t   i_bus_rd_mask,
  input  wire bus_mask_t   i_bus_wr_mask,
  output logic             o_bus_req,
  output logic             o_bus_ack,
  output logic             o_bus_write,
  output bus_addr_t        o_bus_addr,
  output bus_data_t        o_bus_data,
  output bus_mask_t        o_bus_rd_mask,
  output bus_mask_t        o_bus_wr_mask
);

  localparam bus_addr_t ADDR_LAST = ADDR_BASE + bus_addr_t'(4 * (2 ** SIZE)) - 1;

  logic [NUM_KEYS-1:0] keys;
  logic [NUM_KEYS-1:0] keys_next;
  key_code_t           key_code;
  bus_addr_t           offset;
  logic [SIZE-1:0]     word_idx;
  logic                hit;
  logic                rd_bit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Key decode
  assign key_code = i_sample[ADC_BITS-1 -: 3];

  always_comb begin
    keys_next = '0;
    case (key_code)
      KEY_CODE_UP:     keys_next[KEY_UP]     = 1'b1;
      KEY_CODE_RIGHT:  keys_next[KEY_RIGHT]  = 1'b1;
      KEY_CODE_SELECT: keys_next[KEY_SELECT] = 1'b1;
      KEY_CODE_DOWN:   keys_next[KEY_DOWN]   = 1'b1;
      KEY_CODE_LEFT:   keys_next[KEY_LEFT]   = 1'b1;
      default:         keys_next = '0;  // Ladder between positions.
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      keys <= '0;
    end else if (i_sample_valid && (i_sample_chan == adc_chan_t'(JOY_CHANNEL))) begin
      keys <= keys_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register window
  assign hit      = i_bus_req && (i_bus_addr >= ADDR_BASE) && (i_bus_addr <= ADDR_LAST);
  assign offset   = i_bus_addr - ADDR_BASE;
  assign word_idx = offset[SIZE+1:2];  // One key per word.

  always_comb begin
    rd_bit = 1'b0;  // Words past the last key read zero.
    for (int k = 0; k < NUM_KEYS; k++) begin
      if (int'(word_idx) == k) begin
        rd_bit = keys[k];
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bus_req     <= 1'b0;
      o_bus_ack     <= 1'b0;
      o_bus_write   <= 1'b0;
      o_bus_addr    <= '0;
      o_bus_data    <= '0;
      o_bus_rd_mask <= '0;
      o_bus_wr_mask <= '0;
    end else begin
      o_bus_write   <= i_bus_write;
      o_bus_addr    <= i_bus_addr;
      o_bus_rd_mask <= i_bus_rd_mask;
      o_bus_wr_mask <= i_bus_wr_mask;
      if (hit) begin
        o_bus_req  <= 1'b0;  // Taken off the ring.
        o_bus_ack  <= 1'b1;
        o_bus_data <= bus_data_t'(rd_bit);  // Writes answered the same way.
      end else begin
        o_bus_req  <= i_bus_req;
        o_bus_ack  <= i_bus_ack;
        o_bus_data <= i_bus_data;
      end
    end
  end

  ast_hit_answer: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    hit |=> (o_bus_ack && !o_bus_req)
  ) else $error("Window hit not answered on the next cycle");

endmodule

`default_nettype wire

//--- source/joystick.sv
`timescale 1ns/1ps
`default_nettype none

module joystick import joy_pkg::*; #(
  parameter int        SIZE        = 3,
  parameter bus_addr_t ADDR_BASE   = 32'h0000_0100,
  parameter int        JOY_CHANNEL = 3,
  parameter int        CONV_CYCLES = 8,
  parameter int        SCK_DIV     = 2
) (
  input  wire            clk,
  input  wire            i_rst_n,
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ADC pins
  output logic           o_adc_convst,
  output logic           o_adc_sck,
  output logic           o_adc_sdi,
  input  wire            i_adc_sdo,
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ring bus
  input  wire            i_bus_req,
  input  wire            i_bus_ack,
  input  wire            i_bus_write,
  input  wire bus_addr_t i_bus_addr,
  input  wire bus_data_t i_bus_data,
  input  wire bus_mask_t i_bus_rd_mask,
  input  wire bus_mask_t i_bus_wr_mask,
  output logic           o_bus_req,
  output logic           o_bus_ack,
  output logic           o_bus_write,
  output bus_addr_t      o_bus_addr,
  output bus_data_t      o_bus_data,
  output bus_mask_t      o_bus_rd_mask,
  output bus_mask_t      o_bus_wr_mask
);

  logic        sample_valid;
  adc_sample_t sample;
  adc_chan_t   sample_chan;

  adc_serial_ctrl #(
    .CONV_CYCLES (CONV_CYCLES),
    .SCK_DIV     (SCK_DIV)
  ) u_adc (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_adc_sdo      (i_adc_sdo),
    .o_adc_convst   (o_adc_convst),
    .o_adc_sck      (o_adc_sck),
    .o_adc_sdi      (o_adc_sdi),
    .o_sample_valid (sample_valid),
    .o_sample       (sample),
    .o_sample_chan  (sample_chan)
  );

  joy_ring_tap #(
    .SIZE        (SIZE),
    .ADDR_BASE   (ADDR_BASE),
    .JOY_CHANNEL (JOY_CHANNEL)
  ) u_tap (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_sample_valid (sample_valid),
    .i_sample       (sample),
    .i_sample_chan  (sample_chan),
    .i_bus_req      (i_bus_req),
    .i_bus_ack      (i_bus_ack),
    .i_bus_write    (i_bus_write),
    .i_bus_addr     (i_bus_addr),
    .i_bus_data     (i_bus_data),
    .i_bus_rd_mask  (i_bus_rd_mask),
    .i_bus_wr_mask  (i_bus_wr_mask),
    .o_bus_req      (o_bus_req),
    .o_bus_ack      (o_bus_ack),
    .o_bus_write    (o_bus_write),
    .o_bus_addr     (o_bus_addr),
    .o_bus_data     (o_bus_data),
    .o_bus_rd_mask  (o_bus_rd_mask),
    .o_bus_wr_mask  (o_bus_wr_mask)
  );

endmodule

`default_nettype wire

//--- verif/adc_model.sv
`timescale 1ns/1ps
`default_nettype none

module adc_model import joy_pkg::*; (
  input  wire  i_convst,
  input  wire  i_sck,
  input  wire  i_sdi,
  output logic o_sdo,
  output logic o_error
);

  adc_sample_t values [ADC_CHANNELS] = '{default: '0};  // Set by the test tasks.

  adc_chan_t   next_chan  = '0;  // Channel the next configuration word must select.
  adc_chan_t   conv_chan  = '0;
  logic        conv_valid = 1'b0;
  adc_sample_t out_sr     = '0;
  adc_cfg_t    cfg_sr     = '0;
  int          rise_cnt   = 0;
  int          cfg_count  = 0;
  logic        convst_q   = 1'b0;
  logic        sck_q      = 1'b0;
  logic        sdo        = 1'b0;
  logic        err        = 1'b0;

  assign o_sdo   = sdo;
  assign o_error = err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pin edges
  always @(i_convst or i_sck) begin
    if (i_convst && !convst_q) begin
      if ((cfg_count > 0) && (rise_cnt != ADC_BITS)) begin
        $display("ADC model: frame had %0d SCK rising edges instead of %0d.",
                 rise_cnt, ADC_BITS);
        err = 1'b1;
      end
      out_sr   = conv_valid ? values[conv_chan] : '0;  // Converts last configured channel.
      rise_cnt = 0;
    end
    if (!i_convst && convst_q) begin
      sdo = out_sr[ADC_BITS-1];  // MSB is out before the first SCK.
    end
    if (i_sck && !sck_q) begin
      if (rise_cnt < ADC_CFG_BITS) begin
        cfg_sr = {cfg_sr[ADC_CFG_BITS-2:0], i_sdi};
      end
      rise_cnt++;
      if (rise_cnt == ADC_CFG_BITS) begin
        if (cfg_sr !== adc_cfg_word(next_chan)) begin
          $display("ADC model: configuration word %b does not select channel %0d.",
                   cfg_sr, next_chan);
          err = 1'b1;
        end
        conv_chan  = next_chan;
        conv_valid = 1'b1;
        next_chan  = next_chan + 1'b1;  // Wraps after channel 7.
        cfg_count++;
      end
    end
    if (!i_sck && sck_q) begin
      out_sr = {out_sr[ADC_BITS-2:0], 1'b0};
      sdo    = out_sr[ADC_BITS-1];
    end
    convst_q = i_convst;
    sck_q    = i_sck;
  end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

//--- verif/tb_joystick.sv
`timescale 1ns/1ps
`default_nettype none

module tb_joystick import joy_pkg::*; ();

  localparam int        CLK_NS      = 20;
  localparam int        SIZE        = 3;
  localparam bus_addr_t ADDR_BASE   = 32'h0000_0100;
  localparam int        JOY_CHANNEL = 3;
  localparam int        CONV_CYCLES = 8;
  localparam int        SCK_DIV     = 2;
  localparam int        WIN_WORDS   = 2 ** SIZE;
  localparam int        FRAME_CLKS  = CONV_CYCLES + 2 * ADC_BITS * SCK_DIV + 1;
  // The joystick channel comes round once per scan, then its result shifts out.
  localparam int        SETTLE_CLKS = (ADC_CHANNELS + 1) * FRAME_CLKS + 2;
  localparam int        NUM_TESTS   = 5;
  localparam int        NUM_SETTLE  = 10;
  localparam int        TIMEOUT_NS  =
    (NUM_SETTLE * SETTLE_CLKS + NUM_TESTS * 3 * FRAME_CLKS) * CLK_NS + 20000;

  logic                clk;
  logic                rst_n;
  logic                adc_convst;
  logic                adc_sck;
  logic                adc_sdi;
  logic                adc_sdo;
  logic                adc_error;
  logic                bus_req;
  logic                bus_ack;
  logic                bus_write;
  bus_addr_t           bus_addr;
  bus_data_t           bus_data;
  bus_mask_t           bus_rd_mask;
  bus_mask_t           bus_wr_mask;
  logic                out_req;
  logic                out_ack;
  logic                out_write;
  bus_addr_t           out_addr;
  bus_data_t           out_data;
  bus_mask_t           out_rd_mask;
  bus_mask_t           out_wr_mask;
  logic [NUM_KEYS-1:0] exp_keys;

  tb_clkgen #(.PERIOD_NS(CLK_NS)) clkgen0 (.o_clk(clk));

  adc_model adc0 (
    .i_convst (adc_convst),
    .i_sck    (adc_sck),
    .i_sdi    (adc_sdi),
    .o_sdo    (adc_sdo),
    .o_error  (adc_error)
  );

  joystick #(
    .SIZE        (SIZE),
    .ADDR_BASE   (ADDR_BASE),
    .JOY_CHANNEL (JOY_CHANNEL),
    .CONV_CYCLES (CONV_CYCLES),
    .SCK_DIV     (SCK_DIV)
  ) dut0 (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .o_adc_convst  (adc_convst),
    .o_adc_sck     (adc_sck),
    .o_adc_sdi     (adc_sdi),
    .i_adc_sdo     (adc_sdo),
    .i_bus_req     (bus_req),
    .i_bus_ack     (bus_ack),
    .i_bus_write   (bus_write),
    .i_bus_addr    (bus_addr),
    .i_bus_data    (bus_data),
    .i_bus_rd_mask (bus_rd_mask),
    .i_bus_wr_mask (bus_wr_mask),
    .o_bus_req     (out_req),
    .o_bus_ack     (out_ack),
    .o_bus_write   (out_write),
    .o_bus_addr    (out_addr),
    .o_bus_data    (out_data),
    .o_bus_rd_mask (out_rd_mask),
    .o_bus_wr_mask (out_wr_mask)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  task automatic stop_on_failure();
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input string name, input bus_mask_t exp, input bus_mask_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference rules
  function automatic logic in_window(input bus_addr_t addr);
    return (addr >= ADDR_BASE) && (addr <= ADDR_BASE + bus_addr_t'(4 * WIN_WORDS) - 1);
  endfunction

  function automatic bus_addr_t word_addr(input int idx);
    return ADDR_BASE + bus_addr_t'(4 * idx);
  endfunction

  function automatic bus_data_t key_word(input bus_addr_t addr);
    logic [NUM_KEYS-1:0] shifted;
    int                  idx;
    idx = int'((addr - ADDR_BASE) >> 2);
    if (idx >= NUM_KEYS) begin
      return '0;
    end
    shifted = exp_keys >> idx;
    return bus_data_t'(shifted[0]);
  endfunction

  function automatic logic [NUM_KEYS-1:0] keys_for_code(input key_code_t code);
    logic [NUM_KEYS-1:0] keys;
    keys = '0;  // Codes 100, 110 and 111 press nothing.
    if (code == KEY_CODE_UP)     keys[KEY_UP]     = 1'b1;
    if (code == KEY_CODE_RIGHT)  keys[KEY_RIGHT]  = 1'b1;
    if (code == KEY_CODE_SELECT) keys[KEY_SELECT] = 1'b1;
    if (code == KEY_CODE_DOWN)   keys[KEY_DOWN]   = 1'b1;
    if (code == KEY_CODE_LEFT)   keys[KEY_LEFT]   = 1'b1;
    return keys;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  task automatic set_channel(input adc_chan_t ch, input key_code_t code);
    bus_data_t rnd;
    rnd = $urandom;
    adc0.values[ch] = {code, rnd[ADC_BITS-4:0]};  // Low bits are noise on the ladder.
  endtask

  task automatic wait_settle();
    repeat (SETTLE_CLKS) @(posedge clk);
  endtask

  // One ring word in, the registered word checked one clock later.
  task automatic bus_xfer(input string name, input logic req, input logic write,
                          input bus_addr_t addr);
    bus_data_t rnd;
    bus_data_t data;
    logic      ack;
    logic      hit;
    rnd  = $urandom;
    data = $urandom;
    ack  = rnd[0];
    hit  = req && in_window(addr);
    @(posedge clk);
    bus_req     <= req;
    bus_ack     <= ack;
    bus_write   <= write;
    bus_addr    <= addr;
    bus_data    <= data;
    bus_rd_mask <= rnd[7:4];
    bus_wr_mask <= rnd[11:8];
    @(posedge clk);
    bus_req     <= 1'b0;
    bus_ack     <= 1'b0;
    bus_write   <= 1'b0;
    bus_addr    <= '0;
    bus_data    <= '0;
    bus_rd_mask <= '0;
    bus_wr_mask <= '0;
    @(negedge clk);
    check_bit({name, " req"}, hit ? 1'b0 : req, out_req);
    check_bit({name, " ack"}, hit ? 1'b1 : ack, out_ack);
    check_bit({name, " write"}, write, out_write);
    check_data({name, " addr"}, addr, out_addr);
    check_data({name, " data"}, hit ? key_word(addr) : data, out_data);
    check_mask({name, " rd_mask"}, rnd[7:4], out_rd_mask);
    check_mask({name, " wr_mask"}, rnd[11:8], out_wr_mask);
  endtask

  task automatic read_all_words(input string name);
    for (int i = 0; i < WIN_WORDS; i++) begin
      bus_xfer(name, 1'b1, 1'b0, word_addr(i));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests
  task automatic test_reset_state();
    @(negedge clk);
    check_bit("reset req", 1'b0, out_req);
    check_bit("reset ack", 1'b0, out_ack);
    check_bit("reset write", 1'b0, out_write);
    check_data("reset addr", '0, out_addr);
    check_data("reset data", '0, out_data);
    check_mask("reset rd_mask", '0, out_rd_mask);
    check_mask("reset wr_mask", '0, out_wr_mask);
    check_bit("reset convst", 1'b0, adc_convst);
    check_bit("reset sck", 1'b0, adc_sck);
    check_bit("reset sdi", 1'b0, adc_sdi);
  endtask

  task automatic test_pass_through();
    bus_addr_t addr;
    bus_data_t rnd;
    for (int n = 0; n < 24; n++) begin
      addr = $urandom;
      rnd  = $urandom;
      if (in_window(addr)) begin
        addr = addr ^ 32'h8000_0000;
      end
      bus_xfer("pass_through random", rnd[1], rnd[2], addr);
    end
    bus_xfer("pass_through below", 1'b1, 1'b0, ADDR_BASE - 32'd4);
    bus_xfer("pass_through above", 1'b1, 1'b1, word_addr(WIN_WORDS));
    bus_xfer("pass_through no req", 1'b0, 1'b0, word_addr(2));
  endtask

  task automatic test_key_decode();
    key_code_t codes [5];
    codes = '{KEY_CODE_UP, KEY_CODE_RIGHT, KEY_CODE_SELECT, KEY_CODE_DOWN, KEY_CODE_LEFT};
    foreach (codes[i]) begin
      set_channel(adc_chan_t'(JOY_CHANNEL), codes[i]);
      exp_keys = keys_for_code(codes[i]);
      wait_settle();
      read_all_words("key_decode");
    end
  endtask

  task automatic test_no_key();
    key_code_t codes [3];
    codes = '{3'b100, 3'b110, 3'b111};
    foreach (codes[i]) begin
      set_channel(adc_chan_t'(JOY_CHANNEL), codes[i]);
      exp_keys = keys_for_code(codes[i]);
      wait_settle();
      read_all_words("no_key");
    end
    set_channel(adc_chan_t'(JOY_CHANNEL), KEY_CODE_DOWN);
    exp_keys = keys_for_code(KEY_CODE_DOWN);
    wait_settle();
    bus_xfer("no_key write unused", 1'b1, 1'b1, word_addr(NUM_KEYS));
    bus_xfer("no_key write last", 1'b1, 1'b1, word_addr(WIN_WORDS - 1));
    bus_xfer("no_key write key", 1'b1, 1'b1, word_addr(int'(KEY_DOWN)));
    read_all_words("no_key after write");
  endtask

  task automatic test_isolation();
    int cfg_before;
    cfg_before = adc0.cfg_count;
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      if (ch != JOY_CHANNEL) begin
        set_channel(adc_chan_t'(ch), KEY_CODE_UP);
      end
    end
    wait_settle();
    read_all_words("isolation");
    // A stalled scan would leave the keys unchanged as well.
    check_bit("isolation scan count", 1'b1, (adc0.cfg_count - cfg_before) >= ADC_CHANNELS);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Run control
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the tests finished.");
    stop_on_failure();
  end

  initial begin
    @(posedge adc_error);
    $display("The ADC model saw a wrong configuration word or SCK count.");
    stop_on_failure();
  end

  initial begin
    void'($urandom(32'h335f));
    rst_n       = 1'b0;
    bus_req     = 1'b0;
    bus_ack     = 1'b0;
    bus_write   = 1'b0;
    bus_addr    = '0;
    bus_data    = '0;
    bus_rd_mask = '0;
    bus_wr_mask = '0;
    exp_keys    = '0;
    repeat (3) @(posedge clk);
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      set_channel(adc_chan_t'(ch), 3'b111);
    end
    test_reset_state();
    @(posedge clk);
    rst_n <= 1'b1;  // Fourth edge ends reset.
    test_pass_through();
    test_key_decode();
    test_no_key();
    test_isolation();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
